// File: source/wiscCore_cfg.svh
// ------------------------------
// Sizes and encodings for a 16-bit WISC core. Address, data and instruction widths are equal.
// MEM_WORDS must be a power of two; higher address bits wrap onto the array.
// ------------------------------
`ifndef WISCCORE_CFG_SVH
`define WISCCORE_CFG_SVH

// ------------------------------
// Datapath sizes
// ------------------------------

`define WORD_W 16          // Instruction, data and byte-address width.

`define MEM_WORDS 1024     // Depth of the unified memory in 16-bit words.

`define REG_IDX_W 3        // Eight architectural registers.

// ------------------------------
// Encodings
// ------------------------------

`define NOP_INSTR 16'h0800 // Major opcode 00001 with every other field zero.

`endif

// File: source/isaPkg.sv
// ------------------------------
// WISC instruction types. Opcode sits in bits 15:11, Rs in 10:8 and Rt in 7:5.
// ------------------------------
`include "wiscCore_cfg.svh"

package isaPkg;

   typedef logic [`WORD_W-1:0]    word_t;   // One instruction or data word.
   typedef logic [`WORD_W-1:0]    addr_t;   // Byte address, so words sit on even values.
   typedef logic [`REG_IDX_W-1:0] regIdx_t; // Register file index.

   // ------------------------------
   // Major opcodes
   // ------------------------------
   typedef enum logic [4:0] {
      opHalt  = 5'b00000, opNop   = 5'b00001, opSiic  = 5'b00010, opRti   = 5'b00011,
      opJ     = 5'b00100, opJr    = 5'b00101, opJal   = 5'b00110, opJalr  = 5'b00111,
      opAddi  = 5'b01000, opSubi  = 5'b01001, opXori  = 5'b01010, opAndni = 5'b01011,
      opBeqz  = 5'b01100, opBnez  = 5'b01101, opBltz  = 5'b01110, opBgez  = 5'b01111,
      opSt    = 5'b10000, opLd    = 5'b10001, opSlbi  = 5'b10010, opStu   = 5'b10011,
      opRoli  = 5'b10100, opSlli  = 5'b10101, opRori  = 5'b10110, opSrli  = 5'b10111,
      opLbi   = 5'b11000, opBtr   = 5'b11001, opShift = 5'b11010, opArith = 5'b11011,
      opSeq   = 5'b11100, opSlt   = 5'b11101, opSle   = 5'b11110, opSco   = 5'b11111
   } opcode_t;

   // ------------------------------
   // Opcode groups
   // ------------------------------

   // Register-group operations and stores read a second source at bits 7:5.
   function automatic logic readsRt(opcode_t op);
      return op inside {opSt, opStu, opShift, opArith, opSeq, opSlt, opSle, opSco};
   endfunction

   // Immediate forms, loads, conditional branches and register jumps read Rs only.
   function automatic logic readsRs(opcode_t op);
      return readsRt(op) || (op inside {opAddi, opSubi, opXori, opAndni, opRoli, opSlli,
         opRori, opSrli, opLd, opSlbi, opBtr, opBeqz, opBnez, opBltz, opBgez, opJr, opJalr});
   endfunction

   function automatic logic isBranch(opcode_t op);
      return op inside {opBeqz, opBnez, opBltz, opBgez, opJ, opJr, opJal, opJalr};
   endfunction

endpackage

// File: source/memPkg.sv
// ------------------------------
// Pipeline and memory traffic types. Compile after isaPkg.
// ------------------------------
package memPkg;

   // Status of one later pipeline stage as seen from fetch.
   typedef struct packed {
      logic            regWrt;     // Stage will write the register file.
      isaPkg::regIdx_t wrtReg;     // Destination of that write.
      logic            branchInst; // Stage carries a branch or jump.
   } stageWrite_t;

   // One access to the unified memory.
   typedef struct packed {
      logic          valid;
      logic          write;        // High for a store, low for a read.
      isaPkg::addr_t addr;
      isaPkg::word_t wdata;
   } memReq_t;

   // ------------------------------
   // Arbiter result
   // ------------------------------
   typedef enum logic [1:0] {
      grantNone,
      grantFetch,
      grantData
   } grant_t;

endpackage

// File: source/pcUnit.sv
// ------------------------------
// Program counter. Branches are taken only when they retire in write-back.
// err flags an odd PC or a carry out of the increment and holds until reset.
// ------------------------------
`include "wiscCore_cfg.svh"

module pcUnit (
   input  logic          clk,
   input  logic          rstN,
   input  logic          createDump,
   input  logic          branchTaken,
   input  isaPkg::addr_t newPC,
   input  logic          pcNop,
   output isaPkg::addr_t pcAddr,
   output isaPkg::addr_t incPC,
   output logic          err
);
   import isaPkg::*;

   localparam logic [`WORD_W:0] PC_STEP = 2;   // One 16-bit word per fetch.

   addr_t            pcReg;
   addr_t            nextPc;
   logic [`WORD_W:0] incSum;                   // Extra bit keeps the carry out.
   logic             errNow;
   logic             errSticky;

   assign incSum = {1'b0, pcReg} + PC_STEP;
   assign incPC  = incSum[`WORD_W-1:0];
   assign pcAddr = pcReg;

   // A dump outranks a retiring branch, and a branch outranks a stall.
   always_comb begin
      if (createDump) begin
         nextPc = pcReg;                        // Halted, the PC stays put.
      end else if (branchTaken) begin
         nextPc = newPC;                        // Redirect from write-back.
      end else if (pcNop) begin
         nextPc = pcReg;                        // Retry the same fetch.
      end else begin
         nextPc = incPC;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pcReg     <= '0;
         errSticky <= 1'b0;
      end else begin
         pcReg     <= nextPc;
         errSticky <= errSticky | errNow;      // Once set, only reset clears it.
      end
   end

   assign errNow = pcReg[0] | incSum[`WORD_W]; // Misaligned, or stepping past 0xFFFE.
   assign err    = errSticky | errNow;

endmodule

// File: source/memArbiter.sv
// ------------------------------
// Fixed priority between two requesters on one memory port. The data port always wins.
// ------------------------------
module memArbiter (
   input  memPkg::memReq_t fetchReq,
   input  memPkg::memReq_t dataReq,
   output memPkg::memReq_t memPort,
   output memPkg::grant_t  grant
);
   import memPkg::*;

   // ------------------------------
   // Selection
   // ------------------------------

   // A stalled fetch is not queued here; the PC simply presents it again next cycle.
   always_comb begin
      if (dataReq.valid) begin
         memPort = dataReq;                  // Memory stage access takes the cycle.
         grant   = grantData;
      end else if (fetchReq.valid) begin
         memPort = fetchReq;
         grant   = grantFetch;
      end else begin
         memPort = fetchReq;                 // Valid is low, so nothing is written.
         grant   = grantNone;
      end
   end

endmodule

// File: source/unifiedMemory.sv
// ------------------------------
// Word memory shared by fetch and data. Contents are undefined until written.
// Byte address bit 0 is ignored and bits above the array size wrap.
// ------------------------------
`include "wiscCore_cfg.svh"

module unifiedMemory (
   input  logic            clk,
   input  memPkg::memReq_t memPort,
   output isaPkg::word_t   rdata
);
   import isaPkg::*;

   localparam int IDX_W = $clog2(`MEM_WORDS);

   word_t            memArray [`MEM_WORDS];
   logic [IDX_W-1:0] wordIdx;

   assign wordIdx = memPort.addr[IDX_W:1];   // Drop the byte bit and mask high bits.

   // ------------------------------
   // Read and write
   // ------------------------------

   assign rdata = memArray[wordIdx];         // Same-cycle read.

   always_ff @(posedge clk) begin
      if (memPort.valid && memPort.write) begin
         memArray[wordIdx] <= memPort.wdata; // Lands at the edge that ends the request.
      end
   end

endmodule

// File: source/hazardDetect.sv
// ------------------------------
// Fetch hazard check without forwarding. Any pending write to a source register stalls.
// A branch in D, X or M holds fetch until it retires from write-back.
// ------------------------------
`include "wiscCore_cfg.svh"

module hazardDetect (
   input  isaPkg::word_t       fetched,
   input  logic                fetchGranted,
   input  memPkg::stageWrite_t stageD,
   input  memPkg::stageWrite_t stageX,
   input  memPkg::stageWrite_t stageM,
   input  memPkg::stageWrite_t stageW,
   output isaPkg::word_t       instruction,
   output logic                instrValid,
   output logic                branchInstF,
   output logic                pcNop
);
   import isaPkg::*;
   import memPkg::*;

   opcode_t op;
   regIdx_t rs;
   regIdx_t rt;
   logic    useRs;
   logic    useRt;
   logic    rawHazard;
   logic    branchHold;

   // True when a stage is about to write a register this instruction reads.
   function automatic logic pendingWrite(stageWrite_t st, logic used, regIdx_t src);
      return used && st.regWrt && (st.wrtReg == src);
   endfunction

   // ------------------------------
   // Decode
   // ------------------------------

   assign op    = opcode_t'(fetched[15:11]); // All 32 codes are named.
   assign rs    = fetched[10:8];
   assign rt    = fetched[7:5];
   assign useRs = readsRs(op);
   assign useRt = readsRt(op);

   // ------------------------------
   // Hazards
   // ------------------------------

   always_comb begin
      rawHazard = pendingWrite(stageD, useRs, rs) | pendingWrite(stageD, useRt, rt);
      rawHazard = rawHazard | pendingWrite(stageX, useRs, rs) | pendingWrite(stageX, useRt, rt);
      rawHazard = rawHazard | pendingWrite(stageM, useRs, rs) | pendingWrite(stageM, useRt, rt);
      rawHazard = rawHazard | pendingWrite(stageW, useRs, rs) | pendingWrite(stageW, useRt, rt);
   end

   // The write-back branch is left out here because it redirects the PC itself.
   assign branchHold = stageD.branchInst | stageX.branchInst | stageM.branchInst;

   // Losing the memory to the data port also stalls, since fetched is then a data word.
   assign pcNop = ~fetchGranted | rawHazard | branchHold;

   // ------------------------------
   // Outputs
   // ------------------------------

   assign instruction = pcNop ? `NOP_INSTR : fetched;
   assign instrValid  = ~pcNop;
   assign branchInstF = fetchGranted & isBranch(op);

endmodule

// File: source/fetchTop.sv
// ------------------------------
// Fetch front end. D, X, M and W are modeled outside and arrive as status ports.
// A data request takes the memory for the whole cycle and fetch retries the next one.
// ------------------------------
module fetchTop (
   input  logic                clk,
   input  logic                rstN,
   input  isaPkg::addr_t       newPC,
   input  logic                createDump,
   input  memPkg::stageWrite_t stageD,
   input  memPkg::stageWrite_t stageX,
   input  memPkg::stageWrite_t stageM,
   input  memPkg::stageWrite_t stageW,
   input  memPkg::memReq_t     dataReq,
   output isaPkg::word_t       instruction,
   output isaPkg::addr_t       incPC,
   output logic                instrValid,
   output logic                branchInstF,
   output logic                err,
   output isaPkg::word_t       dataRdata
);
   import isaPkg::*;
   import memPkg::*;

   addr_t   pcAddr;
   memReq_t fetchReq;
   memReq_t memPort;
   grant_t  grant;
   word_t   rdata;
   logic    pcNop;
   logic    fetchGranted;

   // Fetch is a read that is requested every cycle.
   assign fetchReq     = '{valid: 1'b1, write: 1'b0, addr: pcAddr, wdata: '0};
   assign fetchGranted = (grant == grantFetch);
   assign dataRdata    = rdata;

   // ------------------------------
   // Program counter and memory
   // ------------------------------

   pcUnit pcUnit_inst (
      .clk         (clk),
      .rstN        (rstN),
      .createDump  (createDump),
      .branchTaken (stageW.branchInst),
      .newPC       (newPC),
      .pcNop       (pcNop),
      .pcAddr      (pcAddr),
      .incPC       (incPC),
      .err         (err)
   );

   memArbiter memArbiter_inst (
      .fetchReq (fetchReq),
      .dataReq  (dataReq),
      .memPort  (memPort),
      .grant    (grant)
   );

   unifiedMemory unifiedMemory_inst (
      .clk     (clk),
      .memPort (memPort),
      .rdata   (rdata)
   );

   // ------------------------------
   // Hazard check
   // ------------------------------

   hazardDetect hazardDetect_inst (
      .fetched      (rdata),
      .fetchGranted (fetchGranted),
      .stageD       (stageD),
      .stageX       (stageX),
      .stageM       (stageM),
      .stageW       (stageW),
      .instruction  (instruction),
      .instrValid   (instrValid),
      .branchInstF  (branchInstF),
      .pcNop        (pcNop)
   );

endmodule

// File: verification/fetchTb.sv
// ------------------------------
// Testbench for the fetch front end. Random stage inputs play the later pipeline stages.
// Fetches stay in the loaded bytes 0 to 254, except at the top of memory in the overflow test.
// ------------------------------
`include "wiscCore_cfg.svh"

module fetchTb;
   timeunit 1ns;
   timeprecision 100ps;

   import isaPkg::*;
   import memPkg::*;

   localparam int IDX_W           = $clog2(`MEM_WORDS);
   localparam int LOAD_WORDS      = 128;                  // Byte addresses 0 to 254.
   localparam int PHASE_CYCLES    = 256;
   localparam int PLANNED_CYCLES  = 4 * 16 + 2 * LOAD_WORDS + 4 * PHASE_CYCLES + 64;
   localparam int WATCHDOG_CYCLES = 16 * PLANNED_CYCLES;   // Generous margin over the test length.

   // Expected fetch results for one cycle.
   typedef struct packed {
      word_t instr;
      logic  valid;
      logic  branchF;
      addr_t nextPc;
      logic  errNow;
   } fetchExp_t;

   logic        clk;
   logic        rstN;
   addr_t       newPC;
   logic        createDump;
   stageWrite_t stageD;
   stageWrite_t stageX;
   stageWrite_t stageM;
   stageWrite_t stageW;
   memReq_t     dataReq;
   word_t       instruction;
   addr_t       incPC;
   logic        instrValid;
   logic        branchInstF;
   logic        err;
   word_t       dataRdata;

   word_t  shadowMem [`MEM_WORDS];                         // Mirrors every data-port write.
   addr_t  shadowPc;
   logic   errSticky;
   integer seed;
   string  testName;
   int     errorCount;
   int     branchCount;
   int     stallCount;
   int     errSeenCount;

   fetchTop fetchTop_inst (
      .clk         (clk),
      .rstN        (rstN),
      .newPC       (newPC),
      .createDump  (createDump),
      .stageD      (stageD),
      .stageX      (stageX),
      .stageM      (stageM),
      .stageW      (stageW),
      .dataReq     (dataReq),
      .instruction (instruction),
      .incPC       (incPC),
      .instrValid  (instrValid),
      .branchInstF (branchInstF),
      .err         (err),
      .dataRdata   (dataRdata)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                              // 40 ns period.
   end

   // ------------------------------
   // Reference model
   // ------------------------------

   // Register-group operations and stores also read bits 7:5.
   function automatic logic readsSecond(logic [4:0] op);
      casez (op)
         5'b1101?, 5'b111??, 5'b10000, 5'b10011: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // Immediates, loads, conditional branches and register jumps read bits 10:8.
   function automatic logic readsFirst(logic [4:0] op);
      casez (op)
         5'b01???, 5'b101??, 5'b10001, 5'b10010, 5'b11001, 5'b001?1: return 1'b1;
         default: return readsSecond(op);
      endcase
   endfunction

   function automatic logic isControl(logic [4:0] op);
      return (op[4:3] == 2'b00 && op[2]) || (op[4:2] == 3'b011);
   endfunction

   function automatic fetchExp_t expectedFetch(addr_t pc, logic dump, addr_t target,
         stageWrite_t d, stageWrite_t x, stageWrite_t m, stageWrite_t w, logic dataBusy);
      fetchExp_t   res;
      stageWrite_t later [4];
      word_t       word;
      logic [4:0]  op;
      logic        hazard;
      logic        hold;
      later[0] = d;
      later[1] = x;
      later[2] = m;
      later[3] = w;
      word     = shadowMem[pc[IDX_W:1]];                   // Bit 0 and high bits are dropped.
      op       = word[15:11];
      hazard   = 1'b0;
      for (int i = 0; i < 4; i++) begin
         if (later[i].regWrt && readsFirst(op) && later[i].wrtReg == word[10:8]) begin
            hazard = 1'b1;
         end
         if (later[i].regWrt && readsSecond(op) && later[i].wrtReg == word[7:5]) begin
            hazard = 1'b1;
         end
      end
      hold        = dataBusy | hazard | d.branchInst | x.branchInst | m.branchInst;
      res.instr   = hold ? word_t'(`NOP_INSTR) : word;
      res.valid   = ~hold;
      res.branchF = ~dataBusy & isControl(op);
      res.errNow  = pc[0] | (pc >= 16'hFFFE);              // Odd, or the step carries out.
      if (dump) begin
         res.nextPc = pc;
      end else if (w.branchInst) begin
         res.nextPc = target;
      end else if (hold) begin
         res.nextPc = pc;
      end else begin
         res.nextPc = pc + 16'd2;
      end
      return res;
   endfunction

   task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
      if (actual !== expected) begin
         errorCount++;
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         $display("Some tests failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Outputs are stable at the falling edge, half a cycle after the inputs moved.
   always @(negedge clk) begin : compareOutputs
      fetchExp_t        want;
      logic [IDX_W-1:0] dataIdx;
      if (!rstN) begin
         shadowPc  = '0;
         errSticky = 1'b0;
      end else begin
         want    = expectedFetch(shadowPc, createDump, newPC, stageD, stageX, stageM, stageW,
                                 dataReq.valid);
         dataIdx = dataReq.addr[IDX_W:1];
         checkValue({testName, " instruction"}, 32'(want.instr), 32'(instruction));
         checkValue({testName, " instrValid"}, 32'(want.valid), 32'(instrValid));
         checkValue({testName, " branchInstF"}, 32'(want.branchF), 32'(branchInstF));
         checkValue({testName, " incPC"}, 32'(addr_t'(shadowPc + 16'd2)), 32'(incPC));
         checkValue({testName, " err"}, 32'(errSticky | want.errNow), 32'(err));
         if (dataReq.valid && !dataReq.write) begin
            checkValue({testName, " dataRdata"}, 32'(shadowMem[dataIdx]), 32'(dataRdata));
         end
         if (dataReq.valid && dataReq.write) begin
            shadowMem[dataIdx] = dataReq.wdata;           // Lands at the coming edge.
         end
         branchCount  += int'(want.branchF);
         stallCount   += int'(!want.valid && testName == "register hazard");
         errSeenCount += int'(errSticky | want.errNow);
         errSticky     = errSticky | want.errNow;
         shadowPc      = want.nextPc;
      end
   end

   // ------------------------------
   // Stimulus helpers
   // ------------------------------

   function automatic stageWrite_t randomStage(logic withWrite, logic withBranch);
      stageWrite_t st;
      logic [31:0] r;
      r             = $random(seed);
      st.regWrt     = withWrite & r[0];
      st.wrtReg     = r[3:1];
      st.branchInst = withBranch & r[4] & r[5];            // About one stage in four.
      return st;
   endfunction

   // Even targets up to 126, so 64 more bytes of fetch stay inside the program.
   function automatic addr_t randomTarget();
      logic [31:0] r;
      r = $random(seed);
      return {9'b0, r[6:1], 1'b0};
   endfunction

   task automatic idleInputs();
      createDump <= 1'b0;
      stageD     <= '0;
      stageX     <= '0;
      stageM     <= '0;
      stageW     <= '0;
      dataReq    <= '0;
   endtask

   task automatic redirect(addr_t target);
      @(posedge clk);
      idleInputs();
      stageW <= '{regWrt: 1'b0, wrtReg: '0, branchInst: 1'b1};
      newPC  <= target;
   endtask

   task automatic assertReset();
      rstN <= 1'b0;
      repeat (16) @(posedge clk);
      rstN <= 1'b1;
   endtask

   task automatic writeWord(addr_t addr, word_t data);
      @(posedge clk);
      idleInputs();
      dataReq <= '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
   endtask

   task automatic idleCycles(int count);
      repeat (count) begin
         @(posedge clk);
         idleInputs();
      end
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------

   initial begin
      logic [31:0] r;
      seed         = 66546;
      rstN         = 1'b0;
      newPC        = '0;
      createDump   = 1'b0;
      stageD       = '0;
      stageX       = '0;
      stageM       = '0;
      stageW       = '0;
      dataReq      = '{valid: 1'b1, write: 1'b1, addr: '0, wdata: '0}; // Keeps fetch off X data.
      errorCount   = 0;
      branchCount  = 0;
      stallCount   = 0;
      errSeenCount = 0;
      testName     = "reset";
      assertReset();

      testName = "program load";
      for (int i = 0; i < LOAD_WORDS; i++) begin
         writeWord(addr_t'(2 * i), word_t'($random(seed)));
      end
      for (int i = 0; i < LOAD_WORDS; i++) begin
         @(posedge clk);
         dataReq <= '{valid: 1'b1, write: 1'b0, addr: addr_t'(2 * i), wdata: '0};
      end

      testName = "sequential fetch";
      idleCycles(LOAD_WORDS - 1);                          // Walks the PC from 0 to 254.

      testName = "register hazard";
      for (int i = 0; i < PHASE_CYCLES; i++) begin
         if (i % 32 == 0) begin
            redirect(randomTarget());
         end else begin
            @(posedge clk);
            idleInputs();
            stageD <= randomStage(1'b1, 1'b0);
            stageX <= randomStage(1'b1, 1'b0);
            stageM <= randomStage(1'b1, 1'b0);
            stageW <= randomStage(1'b1, 1'b0);
         end
      end

      testName = "branch";
      writeWord(16'h0040, 16'h6000);                       // A conditional branch on r0.
      redirect(16'h0040);
      for (int i = 0; i < PHASE_CYCLES; i++) begin
         if (i % 16 == 0) begin
            redirect(randomTarget());
         end else begin
            @(posedge clk);
            idleInputs();
            stageD <= randomStage(1'b0, 1'b1);
            stageX <= randomStage(1'b0, 1'b1);
            stageM <= randomStage(1'b0, 1'b1);
         end
      end

      testName = "arbitration and halt";
      for (int i = 0; i < PHASE_CYCLES; i++) begin
         if (i % 32 == 0) begin
            redirect(randomTarget());
         end else begin
            @(posedge clk);
            idleInputs();
            r = $random(seed);
            if (r[1:0] == 2'd0) begin
               dataReq <= '{valid: 1'b1, write: 1'b0, addr: {8'b0, r[9:3], 1'b0}, wdata: '0};
            end
            createDump <= (r[12:10] == 3'd0);
            if (r[15:13] == 3'd0) begin
               stageW <= '{regWrt: 1'b0, wrtReg: '0, branchInst: 1'b1};
               newPC  <= randomTarget();
            end
         end
      end

      testName = "odd branch target";
      redirect(randomTarget() | 16'h0001);
      idleCycles(8);

      testName = "reset clears err";
      @(posedge clk);
      idleInputs();
      assertReset();
      idleCycles(4);

      testName = "address overflow";
      writeWord(16'hFFFC, word_t'($random(seed)));         // Masks onto the last two words.
      writeWord(16'hFFFE, word_t'($random(seed)));
      redirect(16'hFFFC);
      idleCycles(8);

      @(negedge clk);
      checkValue("branchInstF seen", 32'd1, 32'(branchCount > 0));
      checkValue("hazard stall seen", 32'd1, 32'(stallCount > 0));
      checkValue("err seen", 32'd1, 32'(errSeenCount > 0));
      checkValue("err held at end", 32'd1, 32'(err));
      if (errorCount == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Some tests failed");
      $fatal(1, "Watchdog expired: the tests ran longer than %0d clock cycles", WATCHDOG_CYCLES);
   end

endmodule

// File: compile.f
+incdir+source
source/isaPkg.sv
source/memPkg.sv
source/pcUnit.sv
source/memArbiter.sv
source/unifiedMemory.sv
source/hazardDetect.sv
source/fetchTop.sv
verification/fetchTb.sv

// File: Makefile
# Verilator build and run for the fetch front end.
# Override any variable on the command line, for example: make LOG=run.log

VERILATOR ?= verilator
TOP       ?= fetchTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then exit 1; fi
	@grep -q "All tests passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
